/* flist.f */
+incdir+verif
hw/pktgen_pkg.sv
hw/pktgen_cfg_if.sv
hw/pktgen_beat_if.sv
hw/pktgen_csr_decode.sv
hw/pktgen_prbs23.sv
hw/pktgen_frame_seq.sv
hw/pktgen_beat_out.sv
hw/pktgen_top.sv
verif/pktgen_tb.sv

/* run.sh */
#!/bin/sh
# build and run the frame generator testbench with verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --assert -Wno-fatal --top-module pktgen_tb -f flist.f -o pktgen_sim
./obj_dir/pktgen_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "TB PASSED" sim.log; then
   echo "simulation passed"
   exit 0
else
   echo "simulation failed"
   exit 1
fi

/* verif/pktgen_tb_cases.svh */
// frame generator test table
// one row per case with packet count, length, payload mode, seeds,
// stall and stop control, then expected frames and beats per frame
`ifndef PKTGEN_TB_CASES_SVH
`define PKTGEN_TB_CASES_SVH

localparam int n_cases = 8;

// columns: num_pkts, pkt_len, rnd, seed0, seed1, seed2, stall, stop_after,
//          exp_frames, exp_beats
localparam case_t case_tab [n_cases] = '{
   // header beats, 46 byte payload, empty 2 on eop
   '{32'd1, 14'd64, 1'b0, 32'h5EED0000, 32'h5EED0001, 32'h00025EED, 1'b0, 8'd0, 32'd1, 16'd8},
   // below min length, eop on header beat 1
   '{32'd1, 14'd20, 1'b0, 32'h5EED0000, 32'h5EED0001, 32'h00025EED, 1'b0, 8'd0, 32'd1, 16'd2},
   // above max, payload clamped to 9576
   '{32'd1, 14'd9700, 1'b0, 32'h5EED0000, 32'h5EED0001, 32'h00025EED, 1'b0, 8'd0, 32'd1,
     16'd1199},
   // prbs payload from written seeds
   '{32'd2, 14'd100, 1'b1, 32'h12345678, 32'h9ABCDEF0, 32'h0FEDCBA9, 1'b0, 8'd0, 32'd2, 16'd13},
   // packet count limit
   '{32'd3, 14'd64, 1'b0, 32'h5EED0000, 32'h5EED0001, 32'h00025EED, 1'b0, 8'd0, 32'd3, 16'd8},
   // long run ended by stop during frame 2
   '{32'd100, 14'd64, 1'b0, 32'h5EED0000, 32'h5EED0001, 32'h00025EED, 1'b0, 8'd2, 32'd2, 16'd8},
   // incremental payload under tx_ready stalls
   '{32'd2, 14'd77, 1'b0, 32'h5EED0000, 32'h5EED0001, 32'h00025EED, 1'b1, 8'd0, 32'd2, 16'd10},
   // prbs payload under tx_ready stalls
   '{32'd2, 14'd150, 1'b1, 32'h0BADF00D, 32'h00135790, 32'h02468ACE, 1'b1, 8'd0, 32'd2, 16'd19}
};

`endif

/* verif/pktgen_tb.sv */
`timescale 1ns/100ps
// testbench for the ethernet frame generator
// programs the register bank, runs each table row and checks every beat
// against a frame model built from the length, header and prbs rules
module pktgen_tb;

   typedef struct packed {
      logic [31:0] num_pkts;
      logic [13:0] pkt_len;
      logic        rnd;         // prbs payload
      logic [31:0] seed0;
      logic [31:0] seed1;
      logic [31:0] seed2;
      logic        stall;       // random tx_ready drops
      logic [7:0]  stop_after;  // stop written during this frame, 0 never
      logic [31:0] exp_frames;
      logic [15:0] exp_beats;   // per frame
   } case_t;

   `include "pktgen_tb_cases.svh"

   localparam logic [31:0] da0 = 32'h1122_3344;
   localparam logic [15:0] da1 = 16'h0200;
   localparam logic [31:0] sa0 = 32'h5566_7788;
   localparam logic [15:0] sa1 = 16'h0A0B;
   localparam int timeout_cycles = 5000;

   logic        reset;  // clock
   logic        clk;    // async reset, active high
   logic [7:0]  address;
   logic        write;
   logic [31:0] writedata;
   logic        read;
   logic [31:0] readdata;
   logic        tx_ready;
   logic [63:0] tx_data;
   logic        tx_valid;
   logic        tx_sop;
   logic        tx_eop;
   logic [2:0]  tx_empty;
   logic        tx_error;

   logic [31:0] lcg_state;
   logic [91:0] prbs_model;  // four 23 bit lanes
   logic [13:0] pay_len;
   int          frame_idx;
   int          beat_idx;
   int          case_err;
   int          errors = 0;
   int          checks = 0;
   int          tests_failed = 0;

   pktgen_top pktgen_top_i (
      .reset     (reset),
      .clk       (clk),
      .address   (address),
      .write     (write),
      .writedata (writedata),
      .read      (read),
      .readdata  (readdata),
      .tx_ready  (tx_ready),
      .tx_data   (tx_data),
      .tx_valid  (tx_valid),
      .tx_sop    (tx_sop),
      .tx_eop    (tx_eop),
      .tx_empty  (tx_empty),
      .tx_error  (tx_error)
   );

   always #50 reset = ~reset;  // 100 ns period

   // --------------------
   // models
   function automatic logic [31:0] lcg_next(input logic [31:0] s);
      return s * 32'd1103515245 + 32'd12345;
   endfunction

   function automatic logic [13:0] payload_len(input logic [13:0] len);
      if (len < 14'd24) return 14'd0;   // too short for payload
      if (len > 14'd9600) return 14'd9576;
      return len - 14'd18;
   endfunction

   // 23 shifts of x^23 + x^18 + 1 on each lane
   function automatic logic [91:0] prbs_jump(input logic [91:0] s);
      logic [22:0] lane;
      for (int g = 0; g < 4; g++) begin
         lane = s[g*23 +: 23];
         for (int i = 0; i < 23; i++) begin
            lane = {lane[18] ^ lane[0], lane[22:1]};
         end
         s[g*23 +: 23] = lane;
      end
      return s;
   endfunction

   task automatic compare_value(input string name, input logic [63:0] got,
                                input logic [63:0] exp);
      checks++;
      assert (got === exp) else begin
         $display("FAIL t=%0t %s got=%h exp=%h", $time, name, got, exp);
         case_err++;
      end
   endtask

   // --------------------
   // register bus
   task automatic bus_write(input logic [7:0] a, input logic [31:0] d);
      @(posedge reset);
      #10;
      address   = a;
      writedata = d;
      write     = 1'b1;
      @(posedge reset);  // write lands here
      #10;
      write = 1'b0;
   endtask

   task automatic bus_read(input logic [7:0] a, output logic [31:0] d);
      @(posedge reset);
      #10;
      address = a;
      read    = 1'b1;
      @(posedge reset);  // readdata registered here
      #10;
      read = 1'b0;
      d    = readdata;
   endtask

   // one accepted beat against the model
   task automatic check_beat(input case_t c);
      logic [63:0] exp_data;
      logic        exp_eop;
      int          nb;
      int          k;
      int          npay;
      npay = (int'(pay_len) + 7) / 8;
      nb   = 8;
      k    = beat_idx - 2;
      if (beat_idx == 0) begin
         exp_data = {da1, da0, sa1};
         exp_eop  = 1'b0;
      end else if (beat_idx == 1) begin
         exp_data = {sa0, 16'(pay_len) + 16'd6, 16'(frame_idx)};
         exp_eop  = (pay_len == 14'd0);
      end else begin
         exp_eop = (k == npay - 1);
         if (exp_eop && pay_len[2:0] != 3'd0) nb = int'(pay_len[2:0]);
         if (c.rnd) begin
            prbs_model = prbs_jump(prbs_model);  // word follows its step
            exp_data   = prbs_model[63:0];
         end else begin
            for (int i = 0; i < 8; i++) begin
               exp_data[63-8*i -: 8] = 8'(8*k + i);  // msb first
            end
         end
         for (int i = nb; i < 8; i++) begin
            exp_data[63-8*i -: 8] = 8'h00;  // tail bytes
         end
      end
      compare_value("tx_data", tx_data, exp_data);
      compare_value("tx_sop", 64'(tx_sop), 64'(beat_idx == 0));
      compare_value("tx_eop", 64'(tx_eop), 64'(exp_eop));
      compare_value("tx_empty", 64'(tx_empty), exp_eop ? 64'(8 - nb) : 64'd0);
      compare_value("tx_error", 64'(tx_error), 64'd0);
      if (tx_eop) begin  // frame length as seen on the port
         compare_value("beats_per_frame", 64'(beat_idx + 1), 64'(c.exp_beats));
         frame_idx++;
         beat_idx = 0;
      end else begin
         beat_idx++;
      end
   endtask

   // --------------------
   // tests
   task automatic check_readback();
      logic [31:0] rd;
      case_err = 0;
      bus_read(pktgen_pkg::addr_rndseed0, rd);
      compare_value("rndseed0", 64'(rd), 64'h5EED_0000);
      bus_read(pktgen_pkg::addr_rndseed1, rd);
      compare_value("rndseed1", 64'(rd), 64'h5EED_0001);
      bus_read(pktgen_pkg::addr_rndseed2, rd);
      compare_value("rndseed2", 64'(rd), 64'h0002_5EED);
      bus_read(pktgen_pkg::addr_numpkts, rd);
      compare_value("numpkts", 64'(rd), 64'd0);
      bus_read(8'h01, rd);  // hole in the map
      compare_value("addr 0x01", 64'(rd), 64'd0);
      bus_read(8'h0e, rd);
      compare_value("addr 0x0e", 64'(rd), 64'd0);
      bus_write(pktgen_pkg::addr_macda0, da0);
      bus_write(pktgen_pkg::addr_macda1, {16'hABCD, da1});  // upper half dropped
      bus_write(pktgen_pkg::addr_macsa0, sa0);
      bus_write(pktgen_pkg::addr_macsa1, {16'hFFFF, sa1});
      bus_write(pktgen_pkg::addr_rndseed2, 32'hFFFF_FFFF);
      bus_read(pktgen_pkg::addr_macda1, rd);
      compare_value("macda1", 64'(rd), 64'(da1));
      bus_read(pktgen_pkg::addr_macsa1, rd);
      compare_value("macsa1", 64'(rd), 64'(sa1));
      bus_read(pktgen_pkg::addr_macsa0, rd);
      compare_value("macsa0", 64'(rd), 64'(sa0));
      bus_read(pktgen_pkg::addr_rndseed2, rd);
      compare_value("rndseed2 mask", 64'(rd), 64'h0FFF_FFFF);
      bus_read(pktgen_pkg::addr_start, rd);
      compare_value("start", 64'(rd), 64'd0);
      $display("test readback: errors %0d", case_err);
      errors += case_err;
      if (case_err != 0) tests_failed++;
   endtask

   task automatic run_case(input int n, input case_t c);
      logic [31:0] rd;
      logic        hold_pend;
      logic [63:0] held_data;
      logic [5:0]  held_ctl;  // valid sop eop empty
      int          cycles;
      case_err = 0;
      bus_write(pktgen_pkg::addr_numpkts, c.num_pkts);
      bus_write(pktgen_pkg::addr_pktlength, 32'(c.pkt_len));
      bus_write(pktgen_pkg::addr_random_payload, 32'(c.rnd));
      bus_write(pktgen_pkg::addr_stop, 32'd0);
      bus_write(pktgen_pkg::addr_rndseed0, c.seed0);
      bus_write(pktgen_pkg::addr_rndseed1, c.seed1);
      bus_write(pktgen_pkg::addr_rndseed2, c.seed2);
      prbs_model = {c.seed2[27:0], c.seed1, c.seed0};
      pay_len    = payload_len(c.pkt_len);
      frame_idx  = 0;
      beat_idx   = 0;
      hold_pend  = 1'b0;
      held_data  = '0;
      held_ctl   = '0;
      cycles     = 0;
      bus_write(pktgen_pkg::addr_start, 32'd1);
      while (frame_idx < int'(c.exp_frames) && cycles < timeout_cycles) begin
         @(posedge reset);
         #10;
         cycles++;
         write = 1'b0;  // ends a stop write from the last cycle
         if (hold_pend) begin
            compare_value("tx_data held", tx_data, held_data);
            compare_value("tx_ctl held", 64'({tx_valid, tx_sop, tx_eop, tx_empty}),
                          64'(held_ctl));
         end
         lcg_state = c.stall ? lcg_next(lcg_state) : lcg_state;
         tx_ready  = ~c.stall | (lcg_state[17:16] != 2'b00);  // drops a quarter of cycles
         hold_pend = tx_valid & ~tx_ready;
         held_data = tx_data;
         held_ctl  = {tx_valid, tx_sop, tx_eop, tx_empty};
         if (tx_valid && tx_ready) begin
            if (c.stop_after != 8'd0 && beat_idx == 0 &&
                frame_idx == int'(c.stop_after) - 1) begin
               address   = pktgen_pkg::addr_stop;
               writedata = 32'd1;
               write     = 1'b1;
            end
            check_beat(c);
         end
      end
      if (frame_idx < int'(c.exp_frames)) begin
         $display("ERROR case %0d timed out with %0d of %0d frames received",
                  n, frame_idx, c.exp_frames);
         case_err++;
      end
      tx_ready = 1'b1;
      write    = 1'b0;
      // no further frame may start
      for (int i = 0; i < 40; i++) begin
         @(posedge reset);
         #10;
         compare_value("tx_valid idle", 64'(tx_valid), 64'd0);
      end
      bus_read(pktgen_pkg::addr_txpktcnt, rd);
      compare_value("txpktcnt", 64'(rd), 64'(c.exp_frames));
      $display("test case %0d: pkt_length %0d frames %0d errors %0d",
               n, c.pkt_len, frame_idx, case_err);
      errors += case_err;
      if (case_err != 0) tests_failed++;
   endtask

   // --------------------
   initial begin
      reset     = 1'b0;
      clk       = 1'b1;
      address   = '0;
      write     = 1'b0;
      writedata = '0;
      read      = 1'b0;
      tx_ready  = 1'b1;
      lcg_state = 32'd55;
      repeat (10) @(posedge reset);
      #10;
      clk = 1'b0;
      check_readback();
      for (int n = 0; n < n_cases; n++) begin
         run_case(n, case_tab[n]);
      end
      $display("tests %0d, failed %0d, checks %0d, errors %0d",
               n_cases + 1, tests_failed, checks, errors);
      if (errors == 0) begin
         $display("TB PASSED");
      end else begin
         $display("TB FAILED");
      end
      $finish;
   end

endmodule

/* hw/pktgen_top.sv */
`timescale 1ns/100ps
// ethernet frame generator top level
// register bank, frame sequencer and output stage on one clock
module pktgen_top (
   input  logic                           reset,      // clock
   input  logic                           clk,        // async reset, active high
   input  logic [pktgen_pkg::addr_w-1:0]  address,
   input  logic                           write,
   input  logic [pktgen_pkg::reg_w-1:0]   writedata,
   input  logic                           read,
   output logic [pktgen_pkg::reg_w-1:0]   readdata,
   input  logic                           tx_ready,
   output logic [pktgen_pkg::data_w-1:0]  tx_data,
   output logic                           tx_valid,
   output logic                           tx_sop,
   output logic                           tx_eop,
   output logic [pktgen_pkg::empty_w-1:0] tx_empty,
   output logic                           tx_error
);

   pktgen_cfg_if  cfg_bus ();
   pktgen_beat_if beat_bus ();

   assign tx_error = 1'b0;  // generator never flags errors

   pktgen_csr_decode u_decode (
      .reset     (reset),
      .clk       (clk),
      .address   (address),
      .write     (write),
      .writedata (writedata),
      .read      (read),
      .readdata  (readdata),
      .cfg       (cfg_bus)
   );

   pktgen_frame_seq u_seq (
      .reset (reset),
      .clk   (clk),
      .cfg   (cfg_bus),
      .beat  (beat_bus)
   );

   pktgen_beat_out u_out (
      .reset    (reset),
      .clk      (clk),
      .tx_ready (tx_ready),
      .tx_data  (tx_data),
      .tx_valid (tx_valid),
      .tx_sop   (tx_sop),
      .tx_eop   (tx_eop),
      .tx_empty (tx_empty),
      .beat     (beat_bus)
   );

endmodule

/* hw/pktgen_beat_out.sv */
`timescale 1ns/100ps
// streaming output register
// takes a beat whenever the sink is ready or the register is empty,
// masks unused tail bytes and encodes empty on the eop beat
module pktgen_beat_out (
   input  logic                           reset,     // clock
   input  logic                           clk,       // async reset, active high
   input  logic                           tx_ready,
   output logic [pktgen_pkg::data_w-1:0]  tx_data,
   output logic                           tx_valid,
   output logic                           tx_sop,
   output logic                           tx_eop,
   output logic [pktgen_pkg::empty_w-1:0] tx_empty,
   pktgen_beat_if.out                     beat
);

   logic [3:0]                    empty_n;    // unused bytes in the offered beat
   logic [pktgen_pkg::data_w-1:0] keep_mask;

   assign beat.advance = tx_ready | ~tx_valid;  // ready only matters here
   assign empty_n   = (beat.valid & beat.eop) ? 4'd8 - beat.nbytes : 4'd0;
   assign keep_mask = {pktgen_pkg::data_w{1'b1}} << {empty_n[2:0], 3'b000};

   // --------------------
   // control, held while the sink stalls
   always_ff @(posedge reset or posedge clk) begin
      if (clk) begin
         tx_valid <= 1'b0;
         tx_sop   <= 1'b0;
         tx_eop   <= 1'b0;
         tx_empty <= '0;
      end else if (beat.advance) begin
         tx_valid <= beat.valid;
         tx_sop   <= beat.valid & beat.sop;
         tx_eop   <= beat.valid & beat.eop;
         tx_empty <= empty_n[2:0];
      end
   end

   // data path
   always_ff @(posedge reset) begin
      if (beat.advance) tx_data <= beat.data & keep_mask;  // tail bytes read as 0
   end

   a_hold_on_stall : assert property (@(posedge reset) disable iff (clk)
      (tx_valid && !tx_ready) |=> ($stable(tx_data) && $stable(tx_sop) && $stable(tx_eop)));

endmodule

/* hw/pktgen_frame_seq.sv */
`timescale 1ns/100ps
// frame sequencer
// steps each frame through two header beats and its payload beats,
// keeps the frame count and sequence number and makes the payload words
module pktgen_frame_seq (
   input logic        reset,  // clock
   input logic        clk,    // async reset, active high
   pktgen_cfg_if.seq  cfg,
   pktgen_beat_if.seq beat
);

   logic [2:0]                       state;
   logic [pktgen_pkg::pkt_len_w-1:0] len_calc;   // payload bytes from pkt_length
   logic [pktgen_pkg::pkt_len_w-1:0] pay_len;    // latched per frame
   logic [pktgen_pkg::pkt_len_w-1:0] remain;     // payload bytes not yet sent
   logic [7:0]                       inc_base;   // first byte of the incremental word
   logic [15:0]                      seq_num;
   logic [15:0]                      len_field;
   logic [pktgen_pkg::reg_w-1:0]     tx_count;
   logic [pktgen_pkg::seed_w-1:0]    prbs_all;
   logic [pktgen_pkg::data_w-1:0]    inc_word;
   logic                             launch;
   logic                             last_beat;
   logic                             prbs_step;

   // clamp rules, tiny frames carry no payload
   assign len_calc = (cfg.pkt_length < pktgen_pkg::min_pkt_len) ? '0 :
                     (cfg.pkt_length > pktgen_pkg::max_pkt_len) ? pktgen_pkg::max_payload :
                     cfg.pkt_length - pktgen_pkg::hdr_bytes;
   assign len_field = {2'b00, pay_len} + pktgen_pkg::len_field_add;

   assign launch    = cfg.start & (state == pktgen_pkg::st_idle);
   assign last_beat = (remain <= 14'd8);
   // pre-step so the offered word is the one after its step
   assign prbs_step = beat.advance &
                      (((state == pktgen_pkg::st_hdr1) & (pay_len != '0)) |
                       ((state == pktgen_pkg::st_data) & ~last_beat));
   assign cfg.tx_count = tx_count;

   for (genvar g = 0; g < 4; g++) begin : g_prbs
      pktgen_prbs23 u_prbs (
         .reset  (reset),
         .clk    (clk),
         .load   (launch),
         .enable (prbs_step),
         .seed   (cfg.seed[g*pktgen_pkg::prbs_w +: pktgen_pkg::prbs_w]),
         .state  (prbs_all[g*pktgen_pkg::prbs_w +: pktgen_pkg::prbs_w])
      );
   end

   always_comb begin
      for (int i = 0; i < 8; i++) begin
         inc_word[63-8*i -: 8] = inc_base + 8'(i);  // msb first
      end
   end

   // --------------------
   // beat offered to the output stage
   always_comb begin
      beat.valid  = 1'b0;
      beat.sop    = 1'b0;
      beat.eop    = 1'b0;
      beat.nbytes = 4'd8;
      beat.data   = inc_word;
      case (state)
         pktgen_pkg::st_hdr0: begin
            beat.valid = 1'b1;
            beat.sop   = 1'b1;
            beat.data  = {cfg.da, cfg.sa[47:32]};
         end
         pktgen_pkg::st_hdr1: begin
            beat.valid = 1'b1;
            beat.eop   = (pay_len == '0);  // header only frame
            beat.data  = {cfg.sa[31:0], len_field, seq_num};
         end
         pktgen_pkg::st_data: begin
            beat.valid  = 1'b1;
            beat.eop    = last_beat;
            beat.nbytes = last_beat ? remain[3:0] : 4'd8;
            beat.data   = cfg.random_payload ? prbs_all[63:0] : inc_word;
         end
         default: ;
      endcase
   end

   // --------------------
   // frame fsm
   always_ff @(posedge reset or posedge clk) begin
      if (clk) begin
         state    <= pktgen_pkg::st_idle;
         pay_len  <= '0;
         remain   <= '0;
         inc_base <= '0;
         seq_num  <= '0;
         tx_count <= '0;
      end else begin
         case (state)
            pktgen_pkg::st_idle: if (launch) begin
               state    <= pktgen_pkg::st_hdr0;
               pay_len  <= len_calc;
               seq_num  <= '0;
               tx_count <= '0;
            end
            pktgen_pkg::st_hdr0: if (beat.advance) begin
               state    <= pktgen_pkg::st_hdr1;
               tx_count <= tx_count + 32'd1;  // counted as sop is taken
            end
            pktgen_pkg::st_hdr1: if (beat.advance) begin
               state    <= (pay_len == '0) ? pktgen_pkg::st_gap : pktgen_pkg::st_data;
               remain   <= pay_len;
               inc_base <= '0;
            end
            pktgen_pkg::st_data: if (beat.advance) begin
               remain   <= remain - 14'd8;
               inc_base <= inc_base + 8'd8;
               if (last_beat) state <= pktgen_pkg::st_gap;
            end
            pktgen_pkg::st_gap: begin
               seq_num <= seq_num + 16'd1;
               if (cfg.stop || tx_count >= cfg.number_packet) begin
                  state <= pktgen_pkg::st_idle;
               end else begin
                  state   <= pktgen_pkg::st_hdr0;
                  pay_len <= len_calc;
               end
            end
            default: state <= pktgen_pkg::st_idle;
         endcase
      end
   end

   a_nbytes_range : assert property (@(posedge reset) disable iff (clk)
      beat.valid |-> (beat.nbytes != 4'd0 && beat.nbytes <= 4'd8));

endmodule

/* hw/pktgen_prbs23.sv */
`timescale 1ns/100ps
// prbs23 generator, x^23 + x^18 + 1
// jumps 23 shift steps per enable so each step yields fresh bits
module pktgen_prbs23 (
   input  logic                          reset,   // clock
   input  logic                          clk,     // async reset, active high
   input  logic                          load,
   input  logic                          enable,
   input  logic [pktgen_pkg::prbs_w-1:0] seed,
   output logic [pktgen_pkg::prbs_w-1:0] state
);

   logic [pktgen_pkg::prbs_w-1:0] state_nxt;

   // unrolled shifts, right shift with feedback into the msb
   always_comb begin
      logic [pktgen_pkg::prbs_w-1:0] tmp;
      tmp = state;
      for (int i = 0; i < pktgen_pkg::prbs_w; i++) begin
         tmp = {tmp[18] ^ tmp[0], tmp[pktgen_pkg::prbs_w-1:1]};  // tap at x^18
      end
      state_nxt = tmp;
   end

   always_ff @(posedge reset or posedge clk) begin
      if (clk) begin
         state <= '0;
      end else if (load) begin
         state <= seed;
      end else if (enable) begin
         state <= state_nxt;
      end
   end

endmodule

/* hw/pktgen_csr_decode.sv */
`timescale 1ns/100ps
// frame generator register bank
// decodes bus writes, makes the start pulse and returns registered readback
module pktgen_csr_decode (
   input  logic                          reset,      // clock
   input  logic                          clk,        // async reset, active high
   input  logic [pktgen_pkg::addr_w-1:0] address,
   input  logic                          write,
   input  logic [pktgen_pkg::reg_w-1:0]  writedata,
   input  logic                          read,
   output logic [pktgen_pkg::reg_w-1:0]  readdata,
   pktgen_cfg_if.csr                     cfg
);

   logic [31:0] number_packet;
   logic [13:0] pkt_length;
   logic        random_payload;
   logic        stop;
   logic        start_reg;  // cleared by hardware one cycle after set
   logic        start_d;
   logic [31:0] sa0;
   logic [15:0] sa1;
   logic [31:0] da0;
   logic [15:0] da1;
   logic [31:0] seed0;
   logic [31:0] seed1;
   logic [27:0] seed2;

   // --------------------
   // register writes
   always_ff @(posedge reset or posedge clk) begin
      if (clk) begin
         number_packet  <= '0;
         pkt_length     <= '0;
         random_payload <= 1'b0;
         stop           <= 1'b0;
         start_reg      <= 1'b0;
         start_d        <= 1'b0;
         sa0            <= '0;
         sa1            <= '0;
         da0            <= '0;
         da1            <= '0;
         seed0          <= pktgen_pkg::seed0_rst;
         seed1          <= pktgen_pkg::seed1_rst;
         seed2          <= pktgen_pkg::seed2_rst[27:0];
      end else begin
         start_d <= start_reg;
         if (start_reg) start_reg <= 1'b0;
         if (write) begin
            case (address)
               pktgen_pkg::addr_numpkts:        number_packet  <= writedata;
               pktgen_pkg::addr_random_payload: random_payload <= writedata[0];
               pktgen_pkg::addr_start:          start_reg      <= writedata[0];
               pktgen_pkg::addr_stop:           stop           <= writedata[0];
               pktgen_pkg::addr_macsa0:         sa0            <= writedata;
               pktgen_pkg::addr_macsa1:         sa1            <= writedata[15:0];
               pktgen_pkg::addr_macda0:         da0            <= writedata;
               pktgen_pkg::addr_macda1:         da1            <= writedata[15:0];
               pktgen_pkg::addr_rndseed0:       seed0          <= writedata;
               pktgen_pkg::addr_rndseed1:       seed1          <= writedata;
               pktgen_pkg::addr_rndseed2:       seed2          <= writedata[27:0];
               pktgen_pkg::addr_pktlength:      pkt_length     <= writedata[13:0];
               default: ;
            endcase
         end
      end
   end

   assign cfg.start          = start_reg & ~start_d;  // rising edge only
   assign cfg.number_packet  = number_packet;
   assign cfg.pkt_length     = pkt_length;
   assign cfg.random_payload = random_payload;
   assign cfg.stop           = stop;
   assign cfg.da             = {da1, da0};
   assign cfg.sa             = {sa1, sa0};
   assign cfg.seed           = {seed2, seed1, seed0};

   // --------------------
   // readback, masked bits return 0
   always_ff @(posedge reset or posedge clk) begin
      if (clk) begin
         readdata <= '0;
      end else if (read) begin
         case (address)
            pktgen_pkg::addr_numpkts:        readdata <= number_packet;
            pktgen_pkg::addr_random_payload: readdata <= {31'h0, random_payload};
            pktgen_pkg::addr_start:          readdata <= '0;  // pulse never visible
            pktgen_pkg::addr_stop:           readdata <= {31'h0, stop};
            pktgen_pkg::addr_macsa0:         readdata <= sa0;
            pktgen_pkg::addr_macsa1:         readdata <= {16'h0, sa1};
            pktgen_pkg::addr_macda0:         readdata <= da0;
            pktgen_pkg::addr_macda1:         readdata <= {16'h0, da1};
            pktgen_pkg::addr_txpktcnt:       readdata <= cfg.tx_count;
            pktgen_pkg::addr_rndseed0:       readdata <= seed0;
            pktgen_pkg::addr_rndseed1:       readdata <= seed1;
            pktgen_pkg::addr_rndseed2:       readdata <= {4'h0, seed2};
            pktgen_pkg::addr_pktlength:      readdata <= {18'h0, pkt_length};
            default:                         readdata <= '0;
         endcase
      end
   end

   // back to back start writes still give isolated pulses
   a_start_single : assert property (@(posedge reset) disable iff (clk)
      cfg.start |=> !cfg.start);

endmodule

/* hw/pktgen_beat_if.sv */
`timescale 1ns/100ps
// one streaming beat offered by the sequencer to the output stage
// advance returns when the output stage takes the beat
interface pktgen_beat_if;

   logic [pktgen_pkg::data_w-1:0] data;
   logic                          valid;
   logic                          sop;
   logic                          eop;
   logic [3:0]                    nbytes;   // valid bytes, 1..8
   logic                          advance;

   modport seq (
      output data, valid, sop, eop, nbytes,
      input  advance
   );

   modport out (
      input  data, valid, sop, eop, nbytes,
      output advance
   );

endinterface

/* hw/pktgen_cfg_if.sv */
`timescale 1ns/100ps
// configuration bus from the register bank to the frame sequencer
// the frame count comes back for readback
interface pktgen_cfg_if;

   logic [pktgen_pkg::reg_w-1:0]     number_packet;
   logic [pktgen_pkg::pkt_len_w-1:0] pkt_length;
   logic                             random_payload;  // 0 incremental, 1 prbs
   logic                             stop;
   logic                             start;           // single cycle pulse
   logic [pktgen_pkg::mac_w-1:0]     da;
   logic [pktgen_pkg::mac_w-1:0]     sa;
   logic [pktgen_pkg::seed_w-1:0]    seed;
   logic [pktgen_pkg::reg_w-1:0]     tx_count;        // frames started since start

   modport csr (
      output number_packet, pkt_length, random_payload, stop, start,
      output da, sa, seed,
      input  tx_count
   );

   modport seq (
      input  number_packet, pkt_length, random_payload, stop, start,
      input  da, sa, seed,
      output tx_count
   );

endinterface

/* hw/pktgen_pkg.sv */
// ethernet frame generator shared constants
// register map, bus widths, seed reset values and length limits
package pktgen_pkg;

   // --------------------
   // widths
   localparam int unsigned addr_w    = 8;
   localparam int unsigned reg_w     = 32;
   localparam int unsigned data_w    = 64;
   localparam int unsigned empty_w   = 3;
   localparam int unsigned pkt_len_w = 14;
   localparam int unsigned mac_w     = 48;
   localparam int unsigned seed_w    = 92;  // 4 lfsrs of 23 bits
   localparam int unsigned prbs_w    = 23;

   // --------------------
   // register addresses
   localparam logic [addr_w-1:0] addr_numpkts        = 8'h00;
   localparam logic [addr_w-1:0] addr_random_payload = 8'h02;
   localparam logic [addr_w-1:0] addr_start          = 8'h03;
   localparam logic [addr_w-1:0] addr_stop           = 8'h04;
   localparam logic [addr_w-1:0] addr_macsa0         = 8'h05;
   localparam logic [addr_w-1:0] addr_macsa1         = 8'h06;  // sa[47:32]
   localparam logic [addr_w-1:0] addr_macda0         = 8'h07;
   localparam logic [addr_w-1:0] addr_macda1         = 8'h08;  // da[47:32]
   localparam logic [addr_w-1:0] addr_txpktcnt       = 8'h09;
   localparam logic [addr_w-1:0] addr_rndseed0       = 8'h0a;
   localparam logic [addr_w-1:0] addr_rndseed1       = 8'h0b;
   localparam logic [addr_w-1:0] addr_rndseed2       = 8'h0c;  // 28 bits used
   localparam logic [addr_w-1:0] addr_pktlength      = 8'h0d;

   // nonzero seeds keep the prbs alive when software never writes one
   localparam logic [reg_w-1:0] seed0_rst = 32'h5EED_0000;
   localparam logic [reg_w-1:0] seed1_rst = 32'h5EED_0001;
   localparam logic [reg_w-1:0] seed2_rst = 32'h0002_5EED;

   // --------------------
   // frame length rules
   localparam logic [pkt_len_w-1:0] hdr_bytes   = 14'd18;    // 14 header + 4 fcs
   localparam logic [pkt_len_w-1:0] min_pkt_len = 14'd24;    // below this no payload
   localparam logic [pkt_len_w-1:0] max_pkt_len = 14'd9600;
   localparam logic [pkt_len_w-1:0] max_payload = 14'd9576;  // max_pkt_len - 24
   localparam logic [15:0]          len_field_add = 16'd6;

   // sequencer states
   localparam logic [2:0] st_idle = 3'd0;
   localparam logic [2:0] st_hdr0 = 3'd1;  // da and sa high
   localparam logic [2:0] st_hdr1 = 3'd2;  // sa low, length, seq
   localparam logic [2:0] st_data = 3'd3;
   localparam logic [2:0] st_gap  = 3'd4;  // one idle cycle between frames

endpackage
